// File: mips_isa_pkg.sv
package mips_isa_pkg;

	// Basic field widths
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;

	// Primary opcodes
	localparam opcode_t OP_SPECIAL = 6'h00;
	localparam opcode_t OP_ADDIU   = 6'h09;
	localparam opcode_t OP_ANDI    = 6'h0c;
	localparam opcode_t OP_ORI     = 6'h0d;
	localparam opcode_t OP_LUI     = 6'h0f;
	localparam opcode_t OP_LW      = 6'h23;
	localparam opcode_t OP_SW      = 6'h2b;

	// Funct codes under OP_SPECIAL
	localparam funct_t FN_ADDU = 6'h21;
	localparam funct_t FN_SUBU = 6'h23;
	localparam funct_t FN_AND  = 6'h24;
	localparam funct_t FN_OR   = 6'h25;
	localparam funct_t FN_XOR  = 6'h26;
	localparam funct_t FN_SLT  = 6'h2a;
	localparam funct_t FN_SLTU = 6'h2b;

	// Boot vector
	localparam word_t RESET_PC = 32'hbfc0_0000;

	localparam int REG_COUNT = 32;

endpackage

// File: mips_pipe_pkg.sv
package mips_pipe_pkg;

	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_AND  = 3'd2,
		ALU_OR   = 3'd3,
		ALU_XOR  = 3'd4,
		ALU_SLT  = 3'd5,
		ALU_SLTU = 3'd6,
		ALU_LUI  = 3'd7
	} alu_op_e;

	// Operand source in execute
	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,
		FWD_MEM  = 2'd1,
		FWD_WB   = 2'd2
	} fwd_sel_e;

	// Control bits carried down the pipe, all zero for a no-op
	typedef struct packed {
		logic                   reg_write;
		logic                   mem_read;
		logic                   mem_write;
		logic                   use_imm;
		alu_op_e                alu_op;
		mips_isa_pkg::reg_idx_t dest;
	} ctrl_t;

	typedef struct packed {
		mips_isa_pkg::word_t    pc;
		mips_isa_pkg::word_t    inst;
		ctrl_t                  ctrl;
		mips_isa_pkg::reg_idx_t rs;
		mips_isa_pkg::reg_idx_t rt;
		mips_isa_pkg::word_t    rs_data;
		mips_isa_pkg::word_t    rt_data;
		mips_isa_pkg::word_t    imm;
	} id_ex_t;

	typedef struct packed {
		mips_isa_pkg::word_t pc;
		mips_isa_pkg::word_t inst;
		ctrl_t               ctrl;
		mips_isa_pkg::word_t alu_result;
		mips_isa_pkg::word_t store_data;
	} ex_mem_t;

	typedef struct packed {
		mips_isa_pkg::word_t pc;
		mips_isa_pkg::word_t inst;
		ctrl_t               ctrl;
		mips_isa_pkg::word_t alu_result;
		mips_isa_pkg::word_t load_data;
	} mem_wb_t;

endpackage

// File: fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic                stall_i,
	input  mips_isa_pkg::word_t inst_data_i,
	output mips_isa_pkg::word_t pc_o,
	output mips_isa_pkg::word_t if_pc_o,
	output mips_isa_pkg::word_t if_inst_o
);

	mips_isa_pkg::word_t pc_q;

	assign pc_o = pc_q;

	// PC and IF/ID hold together on a load-use stall
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			pc_q      <= mips_isa_pkg::RESET_PC;
			if_pc_o   <= mips_isa_pkg::RESET_PC;
			// All-zero word decodes as a no-op
			if_inst_o <= '0;
		end
		else if (!stall_i)
		begin
			pc_q      <= pc_q + 32'd4;
			if_pc_o   <= pc_q;
			if_inst_o <= inst_data_i;
		end
	end

endmodule

// File: decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   bubble_i,
	input  mips_isa_pkg::word_t    if_pc_i,
	input  mips_isa_pkg::word_t    if_inst_i,
	input  mips_isa_pkg::word_t    rs_data_i,
	input  mips_isa_pkg::word_t    rt_data_i,
	output mips_isa_pkg::reg_idx_t rs_idx_o,
	output mips_isa_pkg::reg_idx_t rt_idx_o,
	output mips_pipe_pkg::id_ex_t  id_ex_o
);

	mips_isa_pkg::opcode_t  opcode;
	mips_isa_pkg::funct_t   funct;
	mips_isa_pkg::reg_idx_t rd;
	logic [15:0]            imm16;
	mips_pipe_pkg::ctrl_t   ctrl_d;
	mips_isa_pkg::word_t    imm_d;

	mips_pipe_pkg::ctrl_t   ctrl_q;
	mips_isa_pkg::word_t    pc_q, inst_q, rs_data_q, rt_data_q, imm_q;
	mips_isa_pkg::reg_idx_t rs_q, rt_q;

	assign opcode   = if_inst_i[31:26];
	assign rs_idx_o = if_inst_i[25:21];
	assign rt_idx_o = if_inst_i[20:16];
	assign rd       = if_inst_i[15:11];
	assign funct    = if_inst_i[5:0];
	assign imm16    = if_inst_i[15:0];

	always_comb
	begin
		ctrl_d = '0;
		imm_d  = {{16{imm16[15]}}, imm16};
		unique case (opcode)
			mips_isa_pkg::OP_SPECIAL:
			begin
				ctrl_d.reg_write = 1'b1;
				ctrl_d.dest      = rd;
				unique case (funct)
					mips_isa_pkg::FN_ADDU: ctrl_d.alu_op = mips_pipe_pkg::ALU_ADD;
					mips_isa_pkg::FN_SUBU: ctrl_d.alu_op = mips_pipe_pkg::ALU_SUB;
					mips_isa_pkg::FN_AND:  ctrl_d.alu_op = mips_pipe_pkg::ALU_AND;
					mips_isa_pkg::FN_OR:   ctrl_d.alu_op = mips_pipe_pkg::ALU_OR;
					mips_isa_pkg::FN_XOR:  ctrl_d.alu_op = mips_pipe_pkg::ALU_XOR;
					mips_isa_pkg::FN_SLT:  ctrl_d.alu_op = mips_pipe_pkg::ALU_SLT;
					mips_isa_pkg::FN_SLTU: ctrl_d.alu_op = mips_pipe_pkg::ALU_SLTU;
					// Unknown funct retires as a no-op
					default:               ctrl_d = '0;
				endcase
			end
			mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_LW:
			begin
				ctrl_d.reg_write = 1'b1;
				ctrl_d.mem_read  = (opcode == mips_isa_pkg::OP_LW);
				ctrl_d.use_imm   = 1'b1;
				ctrl_d.dest      = rt_idx_o;
			end
			mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI:
			begin
				ctrl_d.reg_write = 1'b1;
				ctrl_d.use_imm   = 1'b1;
				ctrl_d.dest      = rt_idx_o;
				ctrl_d.alu_op    = (opcode == mips_isa_pkg::OP_ANDI) ?
					mips_pipe_pkg::ALU_AND : mips_pipe_pkg::ALU_OR;
				imm_d            = {16'h0000, imm16};
			end
			mips_isa_pkg::OP_LUI:
			begin
				ctrl_d.reg_write = 1'b1;
				ctrl_d.use_imm   = 1'b1;
				ctrl_d.dest      = rt_idx_o;
				ctrl_d.alu_op    = mips_pipe_pkg::ALU_LUI;
				imm_d            = {imm16, 16'h0000};
			end
			mips_isa_pkg::OP_SW:
			begin
				// Address add, rt is only a source here
				ctrl_d.mem_write = 1'b1;
				ctrl_d.use_imm   = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ctrl_q <= '0;
		end
		else if (bubble_i)
		begin
			ctrl_q <= '0;
		end
		else
		begin
			ctrl_q <= ctrl_d;
		end
	end

	always_ff @(posedge clk)
	begin
		pc_q      <= if_pc_i;
		inst_q    <= if_inst_i;
		rs_q      <= rs_idx_o;
		rt_q      <= rt_idx_o;
		rs_data_q <= rs_data_i;
		rt_data_q <= rt_data_i;
		imm_q     <= imm_d;
	end

	assign id_ex_o = '{pc: pc_q, inst: inst_q, ctrl: ctrl_q, rs: rs_q, rt: rt_q,
		rs_data: rs_data_q, rt_data: rt_data_q, imm: imm_q};

	// A bubble must not write anything once it reaches execute
	assert property (@(posedge clk) disable iff (!rst_n_i)
		bubble_i |=> !id_ex_o.ctrl.reg_write && !id_ex_o.ctrl.mem_write);

endmodule

// File: reg_file.sv
`timescale 1ns/100ps

module reg_file (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  mips_isa_pkg::reg_idx_t rs_idx_i,
	input  mips_isa_pkg::reg_idx_t rt_idx_i,
	input  logic                   we_i,
	input  mips_isa_pkg::reg_idx_t wr_idx_i,
	input  mips_isa_pkg::word_t    wr_data_i,
	output mips_isa_pkg::word_t    rs_data_o,
	output mips_isa_pkg::word_t    rt_data_o
);

	mips_isa_pkg::word_t regs [mips_isa_pkg::REG_COUNT];

	// Zero for $0, bypass of the write in flight
	function automatic mips_isa_pkg::word_t read_port(input mips_isa_pkg::reg_idx_t idx);
		if (idx == '0)
			return '0;
		if (we_i && wr_idx_i == idx)
			return wr_data_i;
		return regs[idx];
	endfunction

	always_comb
	begin
		rs_data_o = read_port(rs_idx_i);
		rt_data_o = read_port(rt_idx_i);
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < mips_isa_pkg::REG_COUNT; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (we_i && wr_idx_i != '0)
		begin
			regs[wr_idx_i] <= wr_data_i;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n_i) regs[0] == '0);

endmodule

// File: hazard_forward_unit.sv
`timescale 1ns/100ps

module hazard_forward_unit (
	input  mips_isa_pkg::word_t     if_inst_i,
	input  mips_pipe_pkg::id_ex_t   id_ex_i,
	input  mips_pipe_pkg::ex_mem_t  ex_mem_i,
	input  logic                    wb_we_i,
	input  mips_isa_pkg::reg_idx_t  wb_idx_i,
	output logic                    stall_o,
	output logic                    bubble_o,
	output mips_pipe_pkg::fwd_sel_e fwd_a_o,
	output mips_pipe_pkg::fwd_sel_e fwd_b_o
);

	logic load_use;

	// Youngest producer wins, $0 never forwarded
	function automatic mips_pipe_pkg::fwd_sel_e fwd_select(input mips_isa_pkg::reg_idx_t src);
		if (src == '0)
			return mips_pipe_pkg::FWD_NONE;
		if (ex_mem_i.ctrl.reg_write && ex_mem_i.ctrl.dest == src)
			return mips_pipe_pkg::FWD_MEM;
		if (wb_we_i && wb_idx_i == src)
			return mips_pipe_pkg::FWD_WB;
		return mips_pipe_pkg::FWD_NONE;
	endfunction

	// Load in execute feeding the instruction in decode
	assign load_use = id_ex_i.ctrl.mem_read && id_ex_i.ctrl.dest != '0 &&
		(id_ex_i.ctrl.dest == if_inst_i[25:21] || id_ex_i.ctrl.dest == if_inst_i[20:16]);

	assign stall_o  = load_use;
	assign bubble_o = load_use;

	always_comb
	begin
		fwd_a_o = fwd_select(id_ex_i.rs);
		fwd_b_o = fwd_select(id_ex_i.rt);
	end

endmodule

// File: execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
	input  logic                    clk,
	input  logic                    rst_n_i,
	input  mips_pipe_pkg::id_ex_t   id_ex_i,
	input  mips_pipe_pkg::fwd_sel_e fwd_a_i,
	input  mips_pipe_pkg::fwd_sel_e fwd_b_i,
	input  mips_isa_pkg::word_t     wb_result_i,
	output mips_pipe_pkg::ex_mem_t  ex_mem_o
);

	mips_isa_pkg::word_t  rs_fwd, rt_fwd, op_b, alu_result;
	mips_pipe_pkg::ctrl_t ctrl_q;
	mips_isa_pkg::word_t  pc_q, inst_q, alu_q, store_q;

	function automatic mips_isa_pkg::word_t fwd_mux(input mips_pipe_pkg::fwd_sel_e sel,
			input mips_isa_pkg::word_t reg_data);
		case (sel)
			mips_pipe_pkg::FWD_MEM: return ex_mem_o.alu_result;
			mips_pipe_pkg::FWD_WB:  return wb_result_i;
			default:                return reg_data;
		endcase
	endfunction

	always_comb
	begin
		rs_fwd = fwd_mux(fwd_a_i, id_ex_i.rs_data);
		rt_fwd = fwd_mux(fwd_b_i, id_ex_i.rt_data);
		op_b   = id_ex_i.ctrl.use_imm ? id_ex_i.imm : rt_fwd;
	end

	always_comb
	begin
		case (id_ex_i.ctrl.alu_op)
			mips_pipe_pkg::ALU_ADD:  alu_result = rs_fwd + op_b;
			mips_pipe_pkg::ALU_SUB:  alu_result = rs_fwd - op_b;
			mips_pipe_pkg::ALU_AND:  alu_result = rs_fwd & op_b;
			mips_pipe_pkg::ALU_OR:   alu_result = rs_fwd | op_b;
			mips_pipe_pkg::ALU_XOR:  alu_result = rs_fwd ^ op_b;
			mips_pipe_pkg::ALU_SLT:  alu_result = {31'b0, $signed(rs_fwd) < $signed(op_b)};
			mips_pipe_pkg::ALU_SLTU: alu_result = {31'b0, rs_fwd < op_b};
			// Immediate already shifted in decode
			mips_pipe_pkg::ALU_LUI:  alu_result = id_ex_i.imm;
			default:                 alu_result = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ctrl_q <= '0;
		end
		else
		begin
			ctrl_q <= id_ex_i.ctrl;
		end
	end

	always_ff @(posedge clk)
	begin
		pc_q    <= id_ex_i.pc;
		inst_q  <= id_ex_i.inst;
		alu_q   <= alu_result;
		store_q <= rt_fwd;
	end

	assign ex_mem_o = '{pc: pc_q, inst: inst_q, ctrl: ctrl_q, alu_result: alu_q,
		store_data: store_q};

endmodule

// File: mem_wb_stage.sv
`timescale 1ns/100ps

module mem_wb_stage (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  mips_pipe_pkg::ex_mem_t ex_mem_i,
	input  mips_isa_pkg::word_t    ram_din_i,
	output logic                   ram_en_o,
	output logic [3:0]             ram_we_o,
	output mips_isa_pkg::word_t    ram_addr_o,
	output mips_isa_pkg::word_t    ram_dout_o,
	output logic                   wb_we_o,
	output mips_isa_pkg::reg_idx_t wb_idx_o,
	output mips_isa_pkg::word_t    wb_result_o,
	output mips_isa_pkg::word_t    debug_wb_pc_o,
	output mips_isa_pkg::word_t    debug_wb_inst_o,
	output logic [3:0]             debug_wb_rf_wen_o,
	output mips_isa_pkg::reg_idx_t debug_wb_rf_wnum_o,
	output mips_isa_pkg::word_t    debug_wb_rf_wdata_o
);

	mips_pipe_pkg::ctrl_t   ctrl_q;
	mips_isa_pkg::word_t    pc_q, inst_q, alu_q, load_q;
	mips_pipe_pkg::mem_wb_t mem_wb;

	// Word-only RAM access
	assign ram_en_o   = ex_mem_i.ctrl.mem_read | ex_mem_i.ctrl.mem_write;
	assign ram_we_o   = {4{ex_mem_i.ctrl.mem_write}};
	assign ram_addr_o = ex_mem_i.alu_result;
	assign ram_dout_o = ex_mem_i.store_data;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			ctrl_q <= '0;
		end
		else
		begin
			ctrl_q <= ex_mem_i.ctrl;
		end
	end

	always_ff @(posedge clk)
	begin
		pc_q   <= ex_mem_i.pc;
		inst_q <= ex_mem_i.inst;
		alu_q  <= ex_mem_i.alu_result;
		load_q <= ram_din_i;
	end

	assign mem_wb = '{pc: pc_q, inst: inst_q, ctrl: ctrl_q, alu_result: alu_q,
		load_data: load_q};

	assign wb_we_o     = mem_wb.ctrl.reg_write;
	assign wb_idx_o    = mem_wb.ctrl.dest;
	assign wb_result_o = mem_wb.ctrl.mem_read ? mem_wb.load_data : mem_wb.alu_result;

	// Trace shows no write for $0
	assign debug_wb_pc_o       = mem_wb.pc;
	assign debug_wb_inst_o     = mem_wb.inst;
	assign debug_wb_rf_wen_o   = {4{mem_wb.ctrl.reg_write && mem_wb.ctrl.dest != '0}};
	assign debug_wb_rf_wnum_o  = mem_wb.ctrl.dest;
	assign debug_wb_rf_wdata_o = wb_result_o;

	assert property (@(posedge clk) disable iff (!rst_n_i) (ram_we_o != 4'b0) |-> ram_en_o);

endmodule

// File: mips_core.sv
`timescale 1ns/100ps

module mips_core (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  mips_isa_pkg::word_t    inst_data_i,
	output mips_isa_pkg::word_t    inst_addr_o,
	input  mips_isa_pkg::word_t    ram_din_i,
	output logic                   ram_en_o,
	output logic [3:0]             ram_we_o,
	output mips_isa_pkg::word_t    ram_addr_o,
	output mips_isa_pkg::word_t    ram_dout_o,
	output mips_isa_pkg::word_t    debug_wb_pc_o,
	output mips_isa_pkg::word_t    debug_wb_inst_o,
	output logic [3:0]             debug_wb_rf_wen_o,
	output mips_isa_pkg::reg_idx_t debug_wb_rf_wnum_o,
	output mips_isa_pkg::word_t    debug_wb_rf_wdata_o
);

	mips_isa_pkg::word_t     if_pc;
	mips_isa_pkg::word_t     if_inst;
	mips_isa_pkg::reg_idx_t  rs_idx;
	mips_isa_pkg::reg_idx_t  rt_idx;
	mips_isa_pkg::word_t     rs_data;
	mips_isa_pkg::word_t     rt_data;
	mips_pipe_pkg::id_ex_t   id_ex;
	mips_pipe_pkg::ex_mem_t  ex_mem;
	logic                    stall;
	logic                    bubble;
	mips_pipe_pkg::fwd_sel_e fwd_a;
	mips_pipe_pkg::fwd_sel_e fwd_b;
	logic                    wb_we;
	mips_isa_pkg::reg_idx_t  wb_idx;
	mips_isa_pkg::word_t     wb_result;

	fetch_stage u_fetch (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.stall_i    (stall),
		.inst_data_i(inst_data_i),
		.pc_o       (inst_addr_o),
		.if_pc_o    (if_pc),
		.if_inst_o  (if_inst)
	);

	decode_stage u_decode (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.bubble_i (bubble),
		.if_pc_i  (if_pc),
		.if_inst_i(if_inst),
		.rs_data_i(rs_data),
		.rt_data_i(rt_data),
		.rs_idx_o (rs_idx),
		.rt_idx_o (rt_idx),
		.id_ex_o  (id_ex)
	);

	reg_file u_reg_file (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.rs_idx_i (rs_idx),
		.rt_idx_i (rt_idx),
		.we_i     (wb_we),
		.wr_idx_i (wb_idx),
		.wr_data_i(wb_result),
		.rs_data_o(rs_data),
		.rt_data_o(rt_data)
	);

	hazard_forward_unit u_hazard (
		.if_inst_i(if_inst),
		.id_ex_i  (id_ex),
		.ex_mem_i (ex_mem),
		.wb_we_i  (wb_we),
		.wb_idx_i (wb_idx),
		.stall_o  (stall),
		.bubble_o (bubble),
		.fwd_a_o  (fwd_a),
		.fwd_b_o  (fwd_b)
	);

	execute_stage u_execute (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.id_ex_i    (id_ex),
		.fwd_a_i    (fwd_a),
		.fwd_b_i    (fwd_b),
		.wb_result_i(wb_result),
		.ex_mem_o   (ex_mem)
	);

	mem_wb_stage u_mem_wb (
		.clk                (clk),
		.rst_n_i            (rst_n_i),
		.ex_mem_i           (ex_mem),
		.ram_din_i          (ram_din_i),
		.ram_en_o           (ram_en_o),
		.ram_we_o           (ram_we_o),
		.ram_addr_o         (ram_addr_o),
		.ram_dout_o         (ram_dout_o),
		.wb_we_o            (wb_we),
		.wb_idx_o           (wb_idx),
		.wb_result_o        (wb_result),
		.debug_wb_pc_o      (debug_wb_pc_o),
		.debug_wb_inst_o    (debug_wb_inst_o),
		.debug_wb_rf_wen_o  (debug_wb_rf_wen_o),
		.debug_wb_rf_wnum_o (debug_wb_rf_wnum_o),
		.debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
	);

endmodule

// File: tb_mips_core.sv
`timescale 1ns/100ps

module tb_mips_core;

	localparam int PROG_WORDS   = 256;
	localparam int TAIL_NOPS    = 8;
	localparam int DATA_WORDS   = 64;
	localparam int RESET_CYCLES = 10;
	// 10 reset + 256 issue + up to 256 load stalls + 4 fill = 526, rounded up
	localparam int TIMEOUT_CYCLES = 600;
	localparam mips_isa_pkg::word_t LAST_PC = mips_isa_pkg::RESET_PC + 32'(4 * (PROG_WORDS - 1));

	typedef struct packed {
		mips_isa_pkg::word_t    pc;
		mips_isa_pkg::word_t    inst;
		mips_isa_pkg::reg_idx_t num;
		mips_isa_pkg::word_t    data;
	} reg_write_t;

	// One RAM access, a load or a store
	typedef struct packed {
		logic                is_store;
		mips_isa_pkg::word_t addr;
		mips_isa_pkg::word_t data;
	} mem_access_t;

	logic                   clk = 1'b0;
	logic                   rst_n_i;
	mips_isa_pkg::word_t    inst_data_i;
	mips_isa_pkg::word_t    inst_addr_o;
	mips_isa_pkg::word_t    ram_din_i;
	logic                   ram_en_o;
	logic [3:0]             ram_we_o;
	mips_isa_pkg::word_t    ram_addr_o;
	mips_isa_pkg::word_t    ram_dout_o;
	mips_isa_pkg::word_t    debug_wb_pc_o;
	mips_isa_pkg::word_t    debug_wb_inst_o;
	logic [3:0]             debug_wb_rf_wen_o;
	mips_isa_pkg::reg_idx_t debug_wb_rf_wnum_o;
	mips_isa_pkg::word_t    debug_wb_rf_wdata_o;

	mips_isa_pkg::word_t imem [PROG_WORDS];
	mips_isa_pkg::word_t ram [DATA_WORDS];
	mips_isa_pkg::word_t model_mem [DATA_WORDS];
	mips_isa_pkg::word_t model_regs [mips_isa_pkg::REG_COUNT];
	reg_write_t          exp_writes [$];
	mem_access_t         exp_access [$];
	logic [31:0]         lfsr_state = 32'd6;
	int                  cycle_count = 0;

	mips_core dut_i (
		.clk                (clk),
		.rst_n_i            (rst_n_i),
		.inst_data_i        (inst_data_i),
		.inst_addr_o        (inst_addr_o),
		.ram_din_i          (ram_din_i),
		.ram_en_o           (ram_en_o),
		.ram_we_o           (ram_we_o),
		.ram_addr_o         (ram_addr_o),
		.ram_dout_o         (ram_dout_o),
		.debug_wb_pc_o      (debug_wb_pc_o),
		.debug_wb_inst_o    (debug_wb_inst_o),
		.debug_wb_rf_wen_o  (debug_wb_rf_wen_o),
		.debug_wb_rf_wnum_o (debug_wb_rf_wnum_o),
		.debug_wb_rf_wdata_o(debug_wb_rf_wdata_o)
	);

	always #2 clk = ~clk;

	task automatic end_with_failure();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("error: %s expected %h actual %h", name, expected, actual);
			end_with_failure();
		end
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic mips_isa_pkg::word_t random_inst();
		logic [31:0]            kind;
		logic [31:0]            r;
		logic [31:0]            sel;
		mips_isa_pkg::reg_idx_t rs;
		mips_isa_pkg::reg_idx_t rt;
		mips_isa_pkg::reg_idx_t rd;
		logic [15:0]            imm;
		mips_isa_pkg::funct_t   fn;
		mips_isa_pkg::word_t    inst;
		kind = take_bits(3);
		r    = take_bits(9);
		// Only $0..$7, so dependencies and $0 writes come often
		rs   = {2'b00, r[8:6]};
		rt   = {2'b00, r[5:3]};
		rd   = {2'b00, r[2:0]};
		r    = take_bits(16);
		imm  = r[15:0];
		sel  = take_bits(3);
		case (kind[2:0])
			3'd0, 3'd1, 3'd2:
			begin
				case (sel[2:0])
					3'd1:    fn = mips_isa_pkg::FN_SUBU;
					3'd2:    fn = mips_isa_pkg::FN_AND;
					3'd3:    fn = mips_isa_pkg::FN_OR;
					3'd4:    fn = mips_isa_pkg::FN_XOR;
					3'd5:    fn = mips_isa_pkg::FN_SLT;
					3'd6:    fn = mips_isa_pkg::FN_SLTU;
					default: fn = mips_isa_pkg::FN_ADDU;
				endcase
				inst = {mips_isa_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
			end
			// Base $0, word offset below 256
			3'd5:    inst = {mips_isa_pkg::OP_LW, 5'd0, rt, 8'h00, imm[7:2], 2'b00};
			3'd6:    inst = {mips_isa_pkg::OP_SW, 5'd0, rt, 8'h00, imm[7:2], 2'b00};
			default:
			begin
				case (sel[1:0])
					2'd0:    inst = {mips_isa_pkg::OP_ADDIU, rs, rt, imm};
					2'd1:    inst = {mips_isa_pkg::OP_ANDI, rs, rt, imm};
					2'd2:    inst = {mips_isa_pkg::OP_ORI, rs, rt, imm};
					default: inst = {mips_isa_pkg::OP_LUI, 5'd0, rt, imm};
				endcase
				if (kind[2:0] == 3'd7 && sel[2:0] == 3'd0)
					inst = {6'h3f, rs, rt, imm};
			end
		endcase
		return inst;
	endfunction

	// In-order ISA model, fills the expected write and RAM access queues
	task automatic run_model();
		mips_isa_pkg::word_t    inst;
		mips_isa_pkg::word_t    pc;
		mips_isa_pkg::word_t    a;
		mips_isa_pkg::word_t    b;
		mips_isa_pkg::word_t    imm_s;
		mips_isa_pkg::word_t    imm_z;
		mips_isa_pkg::word_t    addr;
		mips_isa_pkg::word_t    result;
		mips_isa_pkg::reg_idx_t dest;
		logic                   writes;
		reg_write_t             wr;
		mem_access_t            acc;
		for (int i = 0; i < PROG_WORDS; i++)
		begin
			inst   = imem[i];
			pc     = mips_isa_pkg::RESET_PC + 32'(4 * i);
			a      = model_regs[inst[25:21]];
			b      = model_regs[inst[20:16]];
			imm_s  = {{16{inst[15]}}, inst[15:0]};
			imm_z  = {16'h0000, inst[15:0]};
			addr   = a + imm_s;
			dest   = inst[20:16];
			writes = 1'b1;
			result = '0;
			case (inst[31:26])
				mips_isa_pkg::OP_SPECIAL:
				begin
					dest = inst[15:11];
					case (inst[5:0])
						mips_isa_pkg::FN_ADDU: result = a + b;
						mips_isa_pkg::FN_SUBU: result = a - b;
						mips_isa_pkg::FN_AND:  result = a & b;
						mips_isa_pkg::FN_OR:   result = a | b;
						mips_isa_pkg::FN_XOR:  result = a ^ b;
						mips_isa_pkg::FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						mips_isa_pkg::FN_SLTU: result = (a < b) ? 32'd1 : 32'd0;
						default:               writes = 1'b0;
					endcase
				end
				mips_isa_pkg::OP_ADDIU: result = a + imm_s;
				mips_isa_pkg::OP_ANDI:  result = a & imm_z;
				mips_isa_pkg::OP_ORI:   result = a | imm_z;
				mips_isa_pkg::OP_LUI:   result = {inst[15:0], 16'h0000};
				mips_isa_pkg::OP_LW:
				begin
					// A load to $0 still reads the RAM
					result = model_mem[addr[7:2]];
					acc.is_store = 1'b0;
					acc.addr     = addr;
					acc.data     = '0;
					exp_access.push_back(acc);
				end
				mips_isa_pkg::OP_SW:
				begin
					writes = 1'b0;
					model_mem[addr[7:2]] = b;
					acc.is_store = 1'b1;
					acc.addr     = addr;
					acc.data     = b;
					exp_access.push_back(acc);
				end
				default: writes = 1'b0;
			endcase
			// $0 writes are invisible on the trace
			if (writes && dest != 5'd0)
			begin
				model_regs[dest] = result;
				wr.pc   = pc;
				wr.inst = inst;
				wr.num  = dest;
				wr.data = result;
				exp_writes.push_back(wr);
			end
		end
	endtask

	task automatic verify_writeback();
		reg_write_t want;
		if (debug_wb_rf_wen_o != 4'b0000)
		begin
			if (exp_writes.size() == 0)
			begin
				$display("unexpected register write from pc %h", debug_wb_pc_o);
				end_with_failure();
			end
			else
			begin
				want = exp_writes.pop_front();
				compare_value("wb wen", 32'h0000_000f, {28'd0, debug_wb_rf_wen_o});
				compare_value("wb pc", want.pc, debug_wb_pc_o);
				compare_value("wb inst", want.inst, debug_wb_inst_o);
				compare_value("wb wnum", {27'd0, want.num}, {27'd0, debug_wb_rf_wnum_o});
				compare_value("wb wdata", want.data, debug_wb_rf_wdata_o);
			end
		end
	endtask

	task automatic check_ram_access();
		mem_access_t         want;
		mips_isa_pkg::word_t exp_we;
		if (ram_en_o || ram_we_o != 4'b0000)
		begin
			if (exp_access.size() == 0)
			begin
				$display("unexpected RAM access to address %h", ram_addr_o);
				end_with_failure();
			end
			else
			begin
				want   = exp_access.pop_front();
				exp_we = want.is_store ? 32'h0000_000f : 32'h0000_0000;
				compare_value("ram en", 32'd1, {31'd0, ram_en_o});
				compare_value("ram we", exp_we, {28'd0, ram_we_o});
				compare_value("ram addr", want.addr, ram_addr_o);
				if (want.is_store)
				begin
					compare_value("store data", want.data, ram_dout_o);
					ram[ram_addr_o[7:2]] = ram_dout_o;
				end
			end
		end
	endtask

	// Both memories answer for the addresses of the current cycle
	task automatic drive_memories();
		mips_isa_pkg::word_t offset;
		offset = inst_addr_o - mips_isa_pkg::RESET_PC;
		if (offset < 32'(4 * PROG_WORDS))
			inst_data_i = imem[offset[9:2]];
		else
			inst_data_i = '0;
		ram_din_i = ram[ram_addr_o[7:2]];
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, program did not retire", TIMEOUT_CYCLES);
			end_with_failure();
		end
	end

	initial
	begin
		logic done;
		rst_n_i     = 1'b0;
		inst_data_i = '0;
		ram_din_i   = '0;
		for (int i = 0; i < DATA_WORDS; i++)
		begin
			ram[i]       = take_bits(32);
			model_mem[i] = ram[i];
		end
		for (int i = 0; i < mips_isa_pkg::REG_COUNT; i++)
		begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < PROG_WORDS; i++)
		begin
			if (i < PROG_WORDS - TAIL_NOPS)
				imem[i] = random_inst();
			else
				imem[i] = '0;
		end
		run_model();

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n_i = 1'b1;
		compare_value("reset pc", mips_isa_pkg::RESET_PC, inst_addr_o);
		drive_memories();

		done = 1'b0;
		while (!done)
		begin
			@(posedge clk);
			#1;
			verify_writeback();
			check_ram_access();
			drive_memories();
			done = (debug_wb_pc_o === LAST_PC);
		end

		if (exp_writes.size() == 0 && exp_access.size() == 0)
		begin
			$display("Finished with no errors");
			$finish;
		end
		else
		begin
			$display("program retired with %0d register writes and %0d RAM accesses missing",
				exp_writes.size(), exp_access.size());
			end_with_failure();
		end
	end

endmodule

// File: sources.f
mips_isa_pkg.sv
mips_pipe_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
hazard_forward_unit.sv
execute_stage.sv
mem_wb_stage.sv
mips_core.sv
tb_mips_core.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module tb_mips_core -Mdir obj_dir
	./obj_dir/Vtb_mips_core | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || { echo "TEST INCOMPLETE"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
